// ==== project.f ====
verilog/core_config_pkg.sv
verilog/reg_file.sv
verilog/alu_issuer.sv
verilog/alu0.sv
verilog/alu_committer.sv
verilog/alu_cluster_top.sv
sim/tb_alu_cluster.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the ALU cluster testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --top-module tb_alu_cluster -f project.f \
    -o tb_alu_cluster > build.log 2>&1 \
    && ./obj_dir/tb_alu_cluster | tee sim.log \
    && grep -qx "Simulation PASSED" sim.log \
    && echo "run_sim: pass" \
    || { echo "run_sim: fail, see build.log and sim.log"; exit 1; }

// ==== sim/tb_alu_cluster.sv ====
`timescale 1ns/1ps

module tb_alu_cluster;

    localparam int XLEN           = 32;
    localparam int REG_ADDR_W     = 5;
    localparam int N_RANDOM       = 200;
    localparam int N_INSTR        = 12 + N_RANDOM;
    localparam int TIMEOUT_CYCLES = 4 * N_INSTR * 3 + 100;

    logic                      clk;
    logic                      rst_n;
    logic                      i_instr_valid;
    core_config_pkg::alu_cmd_t i_cmd;
    logic [REG_ADDR_W-1:0]     i_rs1, i_rs2, i_rd;
    logic [XLEN-1:0]           i_imm;
    logic                      i_use_imm;
    logic                      o_ready, o_wb_valid, o_carry, o_illegal;
    logic [REG_ADDR_W-1:0]     o_wb_rd;
    logic [XLEN-1:0]           o_wb_data, o_retired;

    // Reference model state
    logic [XLEN-1:0]       shadow [1 << REG_ADDR_W];
    logic [XLEN-1:0]       exp_data, exp_retired;
    logic [REG_ADDR_W-1:0] exp_rd;
    logic                  exp_carry, exp_legal;
    logic                  accept, acc_d1, acc_d2;
    logic [31:0]           lfsr_state;
    int                    legal_issued, value_errors, protocol_errors, cycle_count;

    alu_cluster_top #(.XLEN(XLEN), .REG_ADDR_W(REG_ADDR_W)) dut (.*);

    always #4 clk = ~clk;

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val        = {val[30:0], fb};
        end
        return val;
    endfunction

    // Expected result, carry/borrow and legality
    function automatic void predict(input logic [2:0] cmd, input logic [XLEN-1:0] a, b);
        exp_carry = 1'b0;
        exp_legal = 1'b1;
        case (cmd)
            core_config_pkg::c_ADD: begin
                exp_data  = a + b;
                // Wrapped sum ends up below the first addend
                exp_carry = (exp_data < a);
            end
            core_config_pkg::c_SUB: begin
                exp_data  = a - b;
                exp_carry = (a < b);
            end
            core_config_pkg::c_AND: exp_data = a & b;
            core_config_pkg::c_OR:  exp_data = a | b;
            core_config_pkg::c_XOR: exp_data = a ^ b;
            default: begin
                exp_data  = '0;
                exp_legal = 1'b0;
            end
        endcase
    endfunction

    task automatic report_value(input string name, input logic [XLEN-1:0] expected, actual);
        value_errors++;
        $display("[ERROR] %s expected 0x%h got 0x%h at %0t", name, expected, actual, $time);
    endtask

    task automatic report_protocol(input string msg);
        protocol_errors++;
        $display("Protocol error at %0t: %s", $time, msg);
    endtask

    task automatic wait_ready();
        while (!o_ready) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Ghost drives i_instr_valid once more while the cluster is busy
    task automatic run_instr(input logic [2:0] cmd, input logic [REG_ADDR_W-1:0] rs1, rs2, rd,
                             input logic [XLEN-1:0] imm, input logic use_imm, ghost);
        wait_ready();
        predict(cmd, shadow[rs1], use_imm ? imm : shadow[rs2]);
        exp_rd = rd;
        if (exp_legal) begin
            legal_issued++;
            if (rd != '0) begin
                shadow[rd] = exp_data;
            end
        end
        i_instr_valid = 1'b1;
        i_cmd         = core_config_pkg::alu_cmd_t'(cmd);
        i_rs1         = rs1;
        i_rs2         = rs2;
        i_rd          = rd;
        i_imm         = imm;
        i_use_imm     = use_imm;
        @(posedge clk);
        #1;
        i_instr_valid = 1'b0;
        if (ghost) begin
            i_instr_valid = 1'b1;
            i_rd          = ~rd;
            @(posedge clk);
            #1;
            i_instr_valid = 1'b0;
        end
    endtask

    task automatic check_reset_state();
        assert (o_ready) else report_value("o_ready", XLEN'(1), XLEN'(o_ready));
        assert (!o_wb_valid) else report_value("o_wb_valid", '0, XLEN'(o_wb_valid));
        assert (!o_carry) else report_value("o_carry", '0, XLEN'(o_carry));
        assert (!o_illegal) else report_value("o_illegal", '0, XLEN'(o_illegal));
        assert (o_retired == '0) else report_value("o_retired", '0, o_retired);
    endtask

    // acc_d2 marks the writeback cycle of an accepted instruction
    assign accept = i_instr_valid && o_ready;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_d1      <= 1'b0;
            acc_d2      <= 1'b0;
            exp_retired <= '0;
        end else begin
            acc_d1 <= accept;
            acc_d2 <= acc_d1;
            if (acc_d2 && exp_legal) begin
                exp_retired <= exp_retired + XLEN'(1);
            end
        end
    end

    a_wb_data: assert property (@(posedge clk) disable iff (!rst_n)
        o_wb_valid |-> o_wb_data == exp_data)
        else report_value("o_wb_data", exp_data, $sampled(o_wb_data));
    a_wb_rd: assert property (@(posedge clk) disable iff (!rst_n)
        o_wb_valid |-> o_wb_rd == exp_rd)
        else report_value("o_wb_rd", XLEN'(exp_rd), XLEN'($sampled(o_wb_rd)));
    a_carry: assert property (@(posedge clk) disable iff (!rst_n)
        o_wb_valid |-> o_carry == exp_carry)
        else report_value("o_carry", XLEN'(exp_carry), XLEN'($sampled(o_carry)));
    a_carry_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !o_wb_valid |-> !o_carry) else report_protocol("o_carry high without a writeback");
    a_ready_falls: assert property (@(posedge clk) disable iff (!rst_n)
        accept |=> !o_ready) else report_protocol("o_ready still high after accepting");
    a_ready_held: assert property (@(posedge clk) disable iff (!rst_n)
        acc_d2 |-> !o_ready) else report_protocol("o_ready high before the writeback");
    a_ready_back: assert property (@(posedge clk) disable iff (!rst_n)
        acc_d2 |=> o_ready) else report_protocol("o_ready did not return after writeback");
    a_wb_due: assert property (@(posedge clk) disable iff (!rst_n)
        acc_d2 && exp_legal |-> o_wb_valid) else report_protocol("expected writeback missing");
    a_wb_only: assert property (@(posedge clk) disable iff (!rst_n)
        o_wb_valid |-> acc_d2 && exp_legal)
        else report_protocol("writeback without a legal accepted instruction");
    a_illegal_due: assert property (@(posedge clk) disable iff (!rst_n)
        acc_d2 && !exp_legal |-> o_illegal) else report_protocol("o_illegal pulse missing");
    a_illegal_only: assert property (@(posedge clk) disable iff (!rst_n)
        o_illegal |-> acc_d2 && !exp_legal) else report_protocol("unexpected o_illegal pulse");
    a_retired: assert property (@(posedge clk) disable iff (!rst_n)
        o_retired == exp_retired)
        else report_value("o_retired", exp_retired, $sampled(o_retired));

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        logic [2:0]            cmd;
        logic [REG_ADDR_W-1:0] rs1, rs2, rd;
        logic [XLEN-1:0]       imm;
        logic                  use_imm, ghost;
        clk             = 1'b0;
        rst_n           = 1'b0;
        i_instr_valid   = 1'b0;
        i_cmd           = core_config_pkg::c_ADD;
        i_rs1           = '0;
        i_rs2           = '0;
        i_rd            = '0;
        i_imm           = '0;
        i_use_imm       = 1'b0;
        lfsr_state      = 32'd99670;
        exp_data        = '0;
        exp_rd          = '0;
        exp_carry       = 1'b0;
        exp_legal       = 1'b0;
        legal_issued    = 0;
        value_errors    = 0;
        protocol_errors = 0;
        for (int i = 0; i < (1 << REG_ADDR_W); i++) begin
            shadow[i] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_reset_state();
        // Load x1..x7 with immediates added to x0
        for (int r = 1; r < 8; r++) begin
            imm = XLEN'(take_bits(XLEN));
            run_instr(3'(core_config_pkg::c_ADD), '0, '0, REG_ADDR_W'(r), imm, 1'b1, 1'b0);
        end
        // Write to x0, then read it back through an ADD
        run_instr(3'(core_config_pkg::c_ADD), REG_ADDR_W'(1), REG_ADDR_W'(2), '0, '0,
                  1'b0, 1'b0);
        run_instr(3'(core_config_pkg::c_ADD), '0, '0, REG_ADDR_W'(8), '0, 1'b0, 1'b0);
        run_instr(3'd5, REG_ADDR_W'(1), REG_ADDR_W'(2), REG_ADDR_W'(9), '0, 1'b0, 1'b1);
        run_instr(3'd6, REG_ADDR_W'(3), REG_ADDR_W'(4), REG_ADDR_W'(9), '0, 1'b0, 1'b0);
        run_instr(3'd7, REG_ADDR_W'(5), REG_ADDR_W'(6), REG_ADDR_W'(9), '0, 1'b1, 1'b0);
        for (int n = 0; n < N_RANDOM; n++) begin
            cmd     = 3'(take_bits(3));
            rs1     = REG_ADDR_W'(take_bits(REG_ADDR_W));
            rs2     = REG_ADDR_W'(take_bits(REG_ADDR_W));
            rd      = REG_ADDR_W'(take_bits(REG_ADDR_W));
            imm     = XLEN'(take_bits(XLEN));
            use_imm = 1'(take_bits(1));
            ghost   = 1'(take_bits(1));
            run_instr(cmd, rs1, rs2, rd, imm, use_imm, ghost);
        end
        wait_ready();
        assert (o_retired == XLEN'(legal_issued))
            else report_value("o_retired", XLEN'(legal_issued), o_retired);
        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/alu_cluster_top.sv ====
`timescale 1ns/1ps

module alu_cluster_top #(
    parameter int XLEN       = 32,
    parameter int REG_ADDR_W = 5
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_instr_valid,
    input  core_config_pkg::alu_cmd_t i_cmd,
    input  logic [REG_ADDR_W-1:0]     i_rs1,
    input  logic [REG_ADDR_W-1:0]     i_rs2,
    input  logic [REG_ADDR_W-1:0]     i_rd,
    input  logic [XLEN-1:0]           i_imm,
    input  logic                      i_use_imm,
    output logic                      o_ready,
    output logic                      o_wb_valid,
    output logic [REG_ADDR_W-1:0]     o_wb_rd,
    output logic [XLEN-1:0]           o_wb_data,
    output logic                      o_carry,
    output logic                      o_illegal,
    output logic [XLEN-1:0]           o_retired
);

    logic [REG_ADDR_W-1:0]     rd_addr_a;
    logic [REG_ADDR_W-1:0]     rd_addr_b;
    logic [XLEN-1:0]           rd_data_a;
    logic [XLEN-1:0]           rd_data_b;
    logic                      issue;
    logic [XLEN-1:0]           arg0;
    logic [XLEN-1:0]           arg1;
    core_config_pkg::alu_cmd_t cmd;
    logic [REG_ADDR_W-1:0]     issue_rd;
    logic                      busy;
    logic                      alu_error;
    logic [XLEN-1:0]           res;
    logic [REG_ADDR_W-1:0]     res_rd;
    logic                      valid;
    logic                      carry;
    logic                      clear;

    alu_issuer #(
        .XLEN       (XLEN),
        .REG_ADDR_W (REG_ADDR_W)
    ) u_issuer (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_instr_valid (i_instr_valid),
        .i_cmd         (i_cmd),
        .i_rs1         (i_rs1),
        .i_rs2         (i_rs2),
        .i_rd          (i_rd),
        .i_imm         (i_imm),
        .i_use_imm     (i_use_imm),
        .i_rd_data_a   (rd_data_a),
        .i_rd_data_b   (rd_data_b),
        .i_alu_busy    (busy),
        .i_alu_error   (alu_error),
        .o_ready       (o_ready),
        .o_rd_addr_a   (rd_addr_a),
        .o_rd_addr_b   (rd_addr_b),
        .o_issue       (issue),
        .o_arg0        (arg0),
        .o_arg1        (arg1),
        .o_cmd         (cmd),
        .o_rd          (issue_rd)
    );

    // Writeback port doubles as the register file write port
    reg_file #(
        .XLEN       (XLEN),
        .REG_ADDR_W (REG_ADDR_W)
    ) u_reg_file (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_rd_addr_a (rd_addr_a),
        .i_rd_addr_b (rd_addr_b),
        .i_wr_en     (o_wb_valid),
        .i_wr_addr   (o_wb_rd),
        .i_wr_data   (o_wb_data),
        .o_rd_data_a (rd_data_a),
        .o_rd_data_b (rd_data_b)
    );

    alu0 #(
        .XLEN       (XLEN),
        .REG_ADDR_W (REG_ADDR_W)
    ) u_alu0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_issue       (issue),
        .i_arg0        (arg0),
        .i_arg1        (arg1),
        .i_cmd         (cmd),
        .i_rd          (issue_rd),
        .i_clear       (clear),
        .o_busy        (busy),
        .o_error_issue (alu_error),
        .o_res         (res),
        .o_rd          (res_rd),
        .o_valid       (valid),
        .o_carry       (carry)
    );

    alu_committer #(
        .XLEN       (XLEN),
        .REG_ADDR_W (REG_ADDR_W)
    ) u_committer (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_valid     (valid),
        .i_res       (res),
        .i_rd        (res_rd),
        .i_carry     (carry),
        .i_alu_error (alu_error),
        .o_clear     (clear),
        .o_wb_valid  (o_wb_valid),
        .o_wb_rd     (o_wb_rd),
        .o_wb_data   (o_wb_data),
        .o_carry     (o_carry),
        .o_illegal   (o_illegal),
        .o_retired   (o_retired)
    );

endmodule

// ==== verilog/alu_committer.sv ====
`timescale 1ns/1ps

module alu_committer #(
    parameter int XLEN       = 32,
    parameter int REG_ADDR_W = 5
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  i_valid,
    input  logic [XLEN-1:0]       i_res,
    input  logic [REG_ADDR_W-1:0] i_rd,
    input  logic                  i_carry,
    input  logic                  i_alu_error,
    output logic                  o_clear,
    output logic                  o_wb_valid,
    output logic [REG_ADDR_W-1:0] o_wb_rd,
    output logic [XLEN-1:0]       o_wb_data,
    output logic                  o_carry,
    output logic                  o_illegal,
    output logic [XLEN-1:0]       o_retired
);

    // Result is taken in the cycle it shows up, so clear follows valid
    assign o_clear    = i_valid;
    assign o_wb_valid = i_valid;
    assign o_wb_rd    = i_rd;
    assign o_wb_data  = i_res;

    // Carry only meaningful alongside a writeback
    assign o_carry   = i_valid && i_carry;
    assign o_illegal = i_alu_error;

    // Retirement count, writes to x0 included
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_retired <= '0;
        end else if (o_wb_valid) begin
            o_retired <= o_retired + XLEN'(1);
        end
    end

    // Writeback lasts one cycle, the ALU drops valid after the clear
    a_wb_single: assert property (@(posedge clk) disable iff (!rst_n)
        o_wb_valid |-> i_valid ##1 !i_valid);

endmodule

// ==== verilog/alu0.sv ====
`timescale 1ns/1ps

module alu0 #(
    parameter int XLEN       = 32,
    parameter int REG_ADDR_W = 5
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_issue,
    input  logic [XLEN-1:0]           i_arg0,
    input  logic [XLEN-1:0]           i_arg1,
    input  core_config_pkg::alu_cmd_t i_cmd,
    input  logic [REG_ADDR_W-1:0]     i_rd,
    input  logic                      i_clear,
    output logic                      o_busy,
    output logic                      o_error_issue,
    output logic [XLEN-1:0]           o_res,
    output logic [REG_ADDR_W-1:0]     o_rd,
    output logic                      o_valid,
    output logic                      o_carry
);

    logic [XLEN:0] wide_res;
    logic          legal;
    logic          valid_q;

    // Extra top bit is carry for ADD, borrow for SUB
    always_comb begin
        wide_res = '0;
        legal    = 1'b1;
        case (i_cmd)
            core_config_pkg::c_ADD: begin
                wide_res = {1'b0, i_arg0} + {1'b0, i_arg1};
            end
            core_config_pkg::c_SUB: begin
                wide_res = {1'b0, i_arg0} - {1'b0, i_arg1};
            end
            core_config_pkg::c_AND: begin
                wide_res = {1'b0, i_arg0 & i_arg1};
            end
            core_config_pkg::c_OR: begin
                wide_res = {1'b0, i_arg0 | i_arg1};
            end
            core_config_pkg::c_XOR: begin
                wide_res = {1'b0, i_arg0 ^ i_arg1};
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q       <= 1'b0;
            o_error_issue <= 1'b0;
            o_res         <= '0;
            o_rd          <= '0;
            o_carry       <= 1'b0;
        end else begin
            // Error is a single pulse, no result is produced
            o_error_issue <= i_issue && !legal;
            if (i_issue && legal) begin
                valid_q <= 1'b1;
                o_res   <= wide_res[XLEN-1:0];
                o_rd    <= i_rd;
                o_carry <= wide_res[XLEN];
            end else if (i_clear) begin
                valid_q <= 1'b0;
            end
        end
    end

    // Single operation in flight, busy spans the same window as valid
    assign o_valid = valid_q;
    assign o_busy  = valid_q;

    a_valid_xor_error: assert property (@(posedge clk) disable iff (!rst_n)
        !(o_valid && o_error_issue));

    a_no_issue_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
        i_issue |-> !o_busy);

endmodule

// ==== verilog/alu_issuer.sv ====
`timescale 1ns/1ps

module alu_issuer #(
    parameter int XLEN       = 32,
    parameter int REG_ADDR_W = 5
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_instr_valid,
    input  core_config_pkg::alu_cmd_t i_cmd,
    input  logic [REG_ADDR_W-1:0]     i_rs1,
    input  logic [REG_ADDR_W-1:0]     i_rs2,
    input  logic [REG_ADDR_W-1:0]     i_rd,
    input  logic [XLEN-1:0]           i_imm,
    input  logic                      i_use_imm,
    input  logic [XLEN-1:0]           i_rd_data_a,
    input  logic [XLEN-1:0]           i_rd_data_b,
    input  logic                      i_alu_busy,
    input  logic                      i_alu_error,
    output logic                      o_ready,
    output logic [REG_ADDR_W-1:0]     o_rd_addr_a,
    output logic [REG_ADDR_W-1:0]     o_rd_addr_b,
    output logic                      o_issue,
    output logic [XLEN-1:0]           o_arg0,
    output logic [XLEN-1:0]           o_arg1,
    output core_config_pkg::alu_cmd_t o_cmd,
    output logic [REG_ADDR_W-1:0]     o_rd
);

    core_config_pkg::issue_state_t state;
    core_config_pkg::issue_state_t state_nxt;
    logic                          accept;

    assign o_ready     = (state == core_config_pkg::S_IDLE);
    assign accept      = i_instr_valid && o_ready;
    assign o_issue     = (state == core_config_pkg::S_ISSUE);
    assign o_rd_addr_a = i_rs1;
    assign o_rd_addr_b = i_rs2;

    // Busy lasts one cycle since the committer clears at once,
    // so busy or the error pulse marks the end of the instruction
    always_comb begin
        state_nxt = state;
        case (state)
            core_config_pkg::S_IDLE: begin
                if (accept) begin
                    state_nxt = core_config_pkg::S_ISSUE;
                end
            end
            core_config_pkg::S_ISSUE: begin
                state_nxt = core_config_pkg::S_WAIT;
            end
            core_config_pkg::S_WAIT: begin
                if (i_alu_busy || i_alu_error) begin
                    state_nxt = core_config_pkg::S_IDLE;
                end
            end
            default: begin
                state_nxt = core_config_pkg::S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= core_config_pkg::S_IDLE;
            o_arg0 <= '0;
            o_arg1 <= '0;
            o_cmd  <= core_config_pkg::c_ADD;
            o_rd   <= '0;
        end else begin
            state <= state_nxt;
            // Operands held until the next accept
            if (accept) begin
                o_arg0 <= i_rd_data_a;
                o_arg1 <= i_use_imm ? i_imm : i_rd_data_b;
                o_cmd  <= i_cmd;
                o_rd   <= i_rd;
            end
        end
    end

    a_issue_single: assert property (@(posedge clk) disable iff (!rst_n)
        o_issue |=> !o_issue);

    a_no_ready_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
        i_alu_busy |-> !o_ready);

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps

module reg_file #(
    parameter int XLEN       = 32,
    parameter int REG_ADDR_W = 5
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [REG_ADDR_W-1:0] i_rd_addr_a,
    input  logic [REG_ADDR_W-1:0] i_rd_addr_b,
    input  logic                  i_wr_en,
    input  logic [REG_ADDR_W-1:0] i_wr_addr,
    input  logic [XLEN-1:0]       i_wr_data,
    output logic [XLEN-1:0]       o_rd_data_a,
    output logic [XLEN-1:0]       o_rd_data_b
);

    localparam int DEPTH = 1 << REG_ADDR_W;

    logic [XLEN-1:0] regs [DEPTH];

    // Entry 0 is never written, so it holds its reset value of zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_addr != '0)) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // Combinational read ports
    assign o_rd_data_a = regs[i_rd_addr_a];
    assign o_rd_data_b = regs[i_rd_addr_b];

endmodule

// ==== verilog/core_config_pkg.sv ====
package core_config_pkg;

    // ALU operations, codes 5 to 7 are unused and flagged illegal
    typedef enum logic [2:0] {
        c_ADD = 3'd0,
        c_SUB = 3'd1,
        c_AND = 3'd2,
        c_OR  = 3'd3,
        c_XOR = 3'd4
    } alu_cmd_t;

    // Issuer FSM
    typedef enum logic [1:0] {
        S_IDLE  = 2'd0,
        S_ISSUE = 2'd1,
        S_WAIT  = 2'd2
    } issue_state_t;

endpackage
